// File: verilog/lcdPkg.sv
package lcdPkg;

    // script layout
    localparam int MSG_WIDTH       = 8;
    localparam int ENTRY_WIDTH     = 9;                       // rs above 8 data bits
    localparam int INIT_LEN        = 5;
    localparam int LINE_LEN        = 16;
    localparam int LINE1_BASE      = INIT_LEN;
    localparam int LINE_CHANGE_IDX = LINE1_BASE + LINE_LEN;   // line-2 address command
    localparam int LINE2_BASE      = LINE_CHANGE_IDX + 1;
    localparam int SCRIPT_LEN      = LINE2_BASE + LINE_LEN;   // 38 writes per screen
    localparam int INDEX_WIDTH     = $clog2(SCRIPT_LEN + 1);  // also holds the idle value
    localparam int COL_WIDTH       = $clog2(LINE_LEN);

    // LCD command bytes
    localparam logic [7:0] CMD_FUNCTION_SET = 8'h38;  // 8-bit bus, 2 lines, 5x8 font
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h0C;  // cursor off
    localparam logic [7:0] CMD_CLEAR        = 8'h01;
    localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06;  // increment, no shift
    localparam logic [7:0] CMD_LINE1_ADDR   = 8'h80;
    localparam logic [7:0] CMD_LINE2_ADDR   = 8'hC0;

    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_SPACE = 8'h20;

    // enable pulse
    localparam int ENABLE_CYCLES  = 16;
    localparam int EN_COUNT_WIDTH = $clog2(ENABLE_CYCLES + 1);

    // message code map
    localparam logic [MSG_WIDTH-1:0] MENU_CODE       = 8'd10;  // 0..9 are process screens
    localparam logic [MSG_WIDTH-1:0] QUANTITY_CODE   = 8'd11;
    localparam logic [MSG_WIDTH-1:0] QUALITY_CODE    = 8'd12;
    localparam logic [MSG_WIDTH-1:0] REASON_CODE     = 8'd13;
    localparam logic [MSG_WIDTH-1:0] PROCESS_ID_BASE = 8'd20;  // screen covers 21..30
    localparam logic [MSG_WIDTH-1:0] CONFIRM_BASE    = 8'd30;  // screen covers 31..39
    localparam logic [MSG_WIDTH-1:0] CONFIRM_LAST    = 8'd39;

    // where the code digit lands
    localparam logic [COL_WIDTH-1:0] PROCESS_DIGIT_COL    = 4'd11;  // line 2
    localparam logic [COL_WIDTH-1:0] PROCESS_ID_DIGIT_COL = 4'd15;  // line 1
    localparam logic [COL_WIDTH-1:0] CONFIRM_DIGIT_COL    = 4'd0;   // line 1

    // sequencer states
    localparam int STATE_WIDTH = 3;
    localparam logic [STATE_WIDTH-1:0] SEQ_LOAD    = 3'd0;
    localparam logic [STATE_WIDTH-1:0] SEQ_WAIT    = 3'd1;
    localparam logic [STATE_WIDTH-1:0] SEQ_SETTLE  = 3'd2;
    localparam logic [STATE_WIDTH-1:0] SEQ_ADVANCE = 3'd3;
    localparam logic [STATE_WIDTH-1:0] SEQ_IDLE    = 3'd4;

    // screen text, column 0 in the top byte
    localparam logic [8*LINE_LEN-1:0] PROCESS_LINE1    = "Processo sendo  ";
    localparam logic [8*LINE_LEN-1:0] PROCESS_LINE2    = "executado: 0    ";
    localparam logic [8*LINE_LEN-1:0] MENU_LINE1       = "Escolha:        ";
    localparam logic [8*LINE_LEN-1:0] MENU_LINE2       = "0Exit 1Exec 2Alt";
    localparam logic [8*LINE_LEN-1:0] QUANTITY_LINE1   = "Quantidade de   ";
    localparam logic [8*LINE_LEN-1:0] QUANTITY_LINE2   = "processos:      ";
    localparam logic [8*LINE_LEN-1:0] QUALITY_LINE1    = "Qual proc deseja";
    localparam logic [8*LINE_LEN-1:0] QUALITY_LINE2    = "trocar o indice?";
    localparam logic [8*LINE_LEN-1:0] REASON_LINE1     = "Por qual        ";
    localparam logic [8*LINE_LEN-1:0] REASON_LINE2     = "processo?       ";
    localparam logic [8*LINE_LEN-1:0] BLANK_LINE1      = {LINE_LEN{ASCII_SPACE}};
    localparam logic [8*LINE_LEN-1:0] BLANK_LINE2      = {LINE_LEN{ASCII_SPACE}};
    localparam logic [8*LINE_LEN-1:0] PROCESS_ID_LINE1 = "ID do processo 0";
    localparam logic [8*LINE_LEN-1:0] PROCESS_ID_LINE2 = "que sera exec:  ";
    localparam logic [8*LINE_LEN-1:0] CONFIRM_LINE1    = "0 Com preempcao?";
    localparam logic [8*LINE_LEN-1:0] CONFIRM_LINE2    = "(1 - S/ 0 - N)  ";

endpackage

// File: verilog/lcdWriteIf.sv
`timescale 1ns/1ns

// one LCD write, sequencer to bus driver
interface lcdWriteIf;

    logic [7:0] data;   // byte for the LCD
    logic       rs;     // 1 = character, 0 = command
    logic       start;  // held until done
    logic       done;   // single-cycle pulse

    modport sequencer (
        output data, rs, start,
        input  done
    );

    modport driver (
        input  data, rs, start,
        output done
    );

endinterface

// File: verilog/screenRom.sv
`timescale 1ns/1ns

module screenRom (
    input  logic [lcdPkg::MSG_WIDTH-1:0]   msgCode,
    input  logic [lcdPkg::INDEX_WIDTH-1:0] scriptIndex,
    output logic [lcdPkg::ENTRY_WIDTH-1:0] entry
);
    import lcdPkg::*;

    logic [8*LINE_LEN-1:0] line1Text;
    logic [8*LINE_LEN-1:0] line2Text;
    logic                  digitEn;
    logic                  digitOnLine2;
    logic [COL_WIDTH-1:0]  digitCol;
    logic [7:0]            digitChar;
    logic                  inLine2;
    logic [COL_WIDTH-1:0]  column;
    logic [7:0]            textChar;

    // byte of a line string at a column
    function automatic logic [7:0] charAt(
        input logic [8*LINE_LEN-1:0] text,
        input logic [COL_WIDTH-1:0]  col
    );
        return text[8*(LINE_LEN-1-col) +: 8];
    endfunction

    // screen select from the code ranges
    always_comb begin
        line1Text    = BLANK_LINE1;  // unlisted codes end up blank
        line2Text    = BLANK_LINE2;
        digitEn      = 1'b0;
        digitOnLine2 = 1'b0;
        digitCol     = '0;
        digitChar    = ASCII_ZERO;
        if (msgCode < MENU_CODE) begin
            line1Text    = PROCESS_LINE1;
            line2Text    = PROCESS_LINE2;
            digitEn      = 1'b1;
            digitOnLine2 = 1'b1;
            digitCol     = PROCESS_DIGIT_COL;
            digitChar    = ASCII_ZERO + msgCode;
        end else if (msgCode == MENU_CODE) begin
            line1Text = MENU_LINE1;
            line2Text = MENU_LINE2;
        end else if (msgCode == QUANTITY_CODE) begin
            line1Text = QUANTITY_LINE1;
            line2Text = QUANTITY_LINE2;
        end else if (msgCode == QUALITY_CODE) begin
            line1Text = QUALITY_LINE1;
            line2Text = QUALITY_LINE2;
        end else if (msgCode == REASON_CODE) begin
            line1Text = REASON_LINE1;
            line2Text = REASON_LINE2;
        end else if (msgCode > PROCESS_ID_BASE && msgCode <= CONFIRM_BASE) begin
            line1Text = PROCESS_ID_LINE1;
            line2Text = PROCESS_ID_LINE2;
            digitEn   = 1'b1;
            digitCol  = PROCESS_ID_DIGIT_COL;
            digitChar = ASCII_ZERO + (msgCode - PROCESS_ID_BASE);  // code 30 gives ':'
        end else if (msgCode > CONFIRM_BASE && msgCode <= CONFIRM_LAST) begin
            line1Text = CONFIRM_LINE1;
            line2Text = CONFIRM_LINE2;
            digitEn   = 1'b1;
            digitCol  = CONFIRM_DIGIT_COL;
            digitChar = ASCII_ZERO + (msgCode - CONFIRM_BASE);
        end
    end

    // character for the current script position
    always_comb begin
        inLine2 = (scriptIndex >= INDEX_WIDTH'(LINE2_BASE));
        if (inLine2) begin
            column   = COL_WIDTH'(scriptIndex - INDEX_WIDTH'(LINE2_BASE));
            textChar = charAt(line2Text, column);
        end else begin
            column   = COL_WIDTH'(scriptIndex - INDEX_WIDTH'(LINE1_BASE));
            textChar = charAt(line1Text, column);
        end
        if (digitEn && (inLine2 == digitOnLine2) && (column == digitCol)) begin
            textChar = digitChar;
        end
    end

    always_comb begin
        case (scriptIndex)
            0:               entry = {1'b0, CMD_FUNCTION_SET};
            1:               entry = {1'b0, CMD_DISPLAY_ON};
            2:               entry = {1'b0, CMD_CLEAR};
            3:               entry = {1'b0, CMD_ENTRY_MODE};
            INIT_LEN - 1:    entry = {1'b0, CMD_LINE1_ADDR};
            LINE_CHANGE_IDX: entry = {1'b0, CMD_LINE2_ADDR};
            default:         entry = {1'b1, textChar};  // rs high for characters
        endcase
    end

endmodule

// File: verilog/displaySequencer.sv
`timescale 1ns/1ns

module displaySequencer #(
    parameter int settleCycles = 262143
) (
    input  logic                           iCLK,
    input  logic                           iRST_N,
    input  logic [lcdPkg::MSG_WIDTH-1:0]   msgCode,
    output logic [lcdPkg::INDEX_WIDTH-1:0] scriptIndex,
    input  logic [lcdPkg::ENTRY_WIDTH-1:0] entry,
    lcdWriteIf.sequencer                   wr
);
    import lcdPkg::*;

    logic [STATE_WIDTH-1:0]              state;
    logic [$clog2(settleCycles + 1)-1:0] settleCount;
    logic [MSG_WIDTH-1:0]                latchedCode;  // code of the screen being sent
    logic                                restartPending;
    logic                                codeChanged;

    assign codeChanged = (msgCode != latchedCode);

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            state          <= SEQ_LOAD;
            scriptIndex    <= '0;
            settleCount    <= '0;
            latchedCode    <= '0;
            restartPending <= 1'b0;
            wr.start       <= 1'b0;
        end else begin
            if (codeChanged) begin
                restartPending <= 1'b1;
            end
            case (state)
                SEQ_LOAD: begin
                    wr.start <= 1'b1;
                    if (scriptIndex == '0) begin
                        latchedCode    <= msgCode;  // new screen begins here
                        restartPending <= 1'b0;
                    end
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (wr.done) begin
                        wr.start    <= 1'b0;
                        settleCount <= '0;
                        state       <= SEQ_SETTLE;
                    end
                end
                SEQ_SETTLE: begin
                    if (settleCount == settleCycles - 1) begin
                        state <= SEQ_ADVANCE;
                    end else begin
                        settleCount <= settleCount + 1'b1;
                    end
                end
                SEQ_ADVANCE: begin
                    if (restartPending) begin
                        scriptIndex <= '0;
                        state       <= SEQ_LOAD;
                    end else if (scriptIndex == INDEX_WIDTH'(SCRIPT_LEN - 1)) begin
                        scriptIndex <= INDEX_WIDTH'(SCRIPT_LEN);  // parked past the script
                        state       <= SEQ_IDLE;
                    end else begin
                        scriptIndex <= scriptIndex + 1'b1;
                        state       <= SEQ_LOAD;
                    end
                end
                SEQ_IDLE: begin
                    if (codeChanged) begin
                        scriptIndex <= '0;
                        state       <= SEQ_LOAD;
                    end
                end
                default: state <= SEQ_LOAD;
            endcase
        end
    end

    // request payload, taken from the ROM once per entry
    always_ff @(posedge iCLK) begin
        if (state == SEQ_LOAD) begin
            wr.data <= entry[ENTRY_WIDTH-2:0];
            wr.rs   <= entry[ENTRY_WIDTH-1];
        end
    end

    startHeldToDone: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        $fell(wr.start) |-> $past(wr.done)
    ) else $error("start dropped without done");

    requestStable: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        wr.start && $past(wr.start) |-> $stable({wr.rs, wr.data})
    ) else $error("request changed while start high");

    indexInRange: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        scriptIndex <= SCRIPT_LEN
    ) else $error("script index past end");

endmodule

// File: verilog/lcdBusDriver.sv
`timescale 1ns/1ns

module lcdBusDriver (
    input  logic       iCLK,
    input  logic       iRST_N,
    lcdWriteIf.driver  wr,
    output logic [7:0] lcdData,
    output logic       lcdRw,
    output logic       lcdEn,
    output logic       lcdRs
);
    import lcdPkg::*;

    logic [EN_COUNT_WIDTH-1:0] enCount;  // clocks of enable so far
    logic                      armed;    // start seen low since the last write

    assign lcdRw = 1'b0;  // write-only panel

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            lcdData <= '0;
            lcdRs   <= 1'b0;
            lcdEn   <= 1'b0;
            enCount <= '0;
            armed   <= 1'b0;
            wr.done <= 1'b0;
        end else begin
            wr.done <= 1'b0;
            if (!wr.start) begin
                armed <= 1'b1;
            end
            if (lcdEn) begin
                if (enCount == EN_COUNT_WIDTH'(ENABLE_CYCLES)) begin
                    lcdEn   <= 1'b0;
                    wr.done <= 1'b1;  // same edge as the falling enable
                end else begin
                    enCount <= enCount + 1'b1;
                end
            end else if (wr.start && armed) begin
                lcdData <= wr.data;
                lcdRs   <= wr.rs;
                lcdEn   <= 1'b1;
                enCount <= EN_COUNT_WIDTH'(1);
                armed   <= 1'b0;  // stale start after done is ignored
            end
        end
    end

    // enable pulse is exactly ENABLE_CYCLES wide
    enablePulseWidth: assert property (
        @(posedge iCLK) disable iff (!iRST_N)
        $rose(lcdEn) |-> lcdEn [*ENABLE_CYCLES] ##1 !lcdEn
    ) else $error("lcdEn pulse width wrong");

endmodule

// File: verilog/lcdMessageTop.sv
`timescale 1ns/1ns

module lcdMessageTop #(
    parameter int settleCycles = 262143
) (
    input  logic                         iCLK,
    input  logic                         iRST_N,
    input  logic [lcdPkg::MSG_WIDTH-1:0] msgCode,
    output logic [7:0]                   lcdData,
    output logic                         lcdRw,
    output logic                         lcdEn,
    output logic                         lcdRs
);
    import lcdPkg::*;

    logic [INDEX_WIDTH-1:0] scriptIndex;
    logic [ENTRY_WIDTH-1:0] entry;

    lcdWriteIf wrBus ();

    displaySequencer #(
        .settleCycles(settleCycles)
    ) seqInst (
        .iCLK       (iCLK),
        .iRST_N     (iRST_N),
        .msgCode    (msgCode),
        .scriptIndex(scriptIndex),
        .entry      (entry),
        .wr         (wrBus.sequencer)
    );

    // ROM follows the live code, the sequencer restarts on a change
    screenRom romInst (
        .msgCode    (msgCode),
        .scriptIndex(scriptIndex),
        .entry      (entry)
    );

    lcdBusDriver drvInst (
        .iCLK   (iCLK),
        .iRST_N (iRST_N),
        .wr     (wrBus.driver),
        .lcdData(lcdData),
        .lcdRw  (lcdRw),
        .lcdEn  (lcdEn),
        .lcdRs  (lcdRs)
    );

endmodule

// File: bench/lcdBusMonitor.sv
`timescale 1ns/1ns

module lcdBusMonitor #(
    parameter int settleCycles = 20
) (
    input  logic                         iCLK,
    input  logic                         iRST_N,
    input  logic [lcdPkg::MSG_WIDTH-1:0] msgCode,
    input  logic [7:0]                   lcdData,
    input  logic                         lcdRw,
    input  logic                         lcdEn,
    input  logic                         lcdRs,
    output int                           errorCount,
    output int                           writesSeen,
    output int                           screensDone
);
    import lcdPkg::*;

    logic                   prevEn;
    logic                   havePulse;   // gap check starts after the first pulse
    logic                   changeSeen;  // code differs from the screen being checked
    logic [MSG_WIDTH-1:0]   screenCode;
    logic [ENTRY_WIDTH-1:0] wantEntry;
    int                     pos;
    int                     highCount;
    int                     lowCount;

    // expected write at a script position, built from the screen rules
    function automatic logic [ENTRY_WIDTH-1:0] expectedEntry(
        input logic [MSG_WIDTH-1:0] code,
        input int                   idx
    );
        logic [8*LINE_LEN-1:0] top;
        logic [8*LINE_LEN-1:0] bottom;
        logic [8*LINE_LEN-1:0] text;
        int                    col;
        top    = BLANK_LINE1;
        bottom = BLANK_LINE2;
        if (code <= 9) begin
            top    = PROCESS_LINE1;
            bottom = PROCESS_LINE2;
            bottom[8*(LINE_LEN-1-11) +: 8] = ASCII_ZERO + code;  // digit at column 11
        end else if (code == 10) begin
            top    = MENU_LINE1;
            bottom = MENU_LINE2;
        end else if (code == 11) begin
            top    = QUANTITY_LINE1;
            bottom = QUANTITY_LINE2;
        end else if (code == 12) begin
            top    = QUALITY_LINE1;
            bottom = QUALITY_LINE2;
        end else if (code == 13) begin
            top    = REASON_LINE1;
            bottom = REASON_LINE2;
        end else if (code >= 21 && code <= 30) begin
            top    = PROCESS_ID_LINE1;
            bottom = PROCESS_ID_LINE2;
            top[7:0] = ASCII_ZERO + 8'(code - 8'd20);  // last column of line 1
        end else if (code >= 31 && code <= 39) begin
            top    = CONFIRM_LINE1;
            bottom = CONFIRM_LINE2;
            top[8*LINE_LEN-1 -: 8] = ASCII_ZERO + 8'(code - 8'd30);
        end
        if (idx < LINE_CHANGE_IDX) begin
            text = top;
            col  = idx - LINE1_BASE;
        end else begin
            text = bottom;
            col  = idx - LINE2_BASE;
        end
        case (idx)
            0:               expectedEntry = {1'b0, CMD_FUNCTION_SET};
            1:               expectedEntry = {1'b0, CMD_DISPLAY_ON};
            2:               expectedEntry = {1'b0, CMD_CLEAR};
            3:               expectedEntry = {1'b0, CMD_ENTRY_MODE};
            4:               expectedEntry = {1'b0, CMD_LINE1_ADDR};
            LINE_CHANGE_IDX: expectedEntry = {1'b0, CMD_LINE2_ADDR};
            default:         expectedEntry = {1'b1, text[8*(LINE_LEN-1-col) +: 8]};
        endcase
    endfunction

    task automatic checkValue(
        input string      name,
        input logic [7:0] expected,
        input logic [7:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    initial begin
        errorCount  = 0;
        writesSeen  = 0;
        screensDone = 0;
    end

    // outputs change on the rising edge, so sample on the falling one
    always @(negedge iCLK) begin
        if (!iRST_N) begin
            checkValue("lcdData", 8'h00, lcdData);
            checkValue("lcdEn", 8'h00, {7'b0, lcdEn});
            checkValue("lcdRs", 8'h00, {7'b0, lcdRs});
            prevEn     = 1'b0;
            havePulse  = 1'b0;
            changeSeen = 1'b0;
            screenCode = msgCode;
            pos        = 0;
            highCount  = 0;
            lowCount   = 0;
        end else begin
            checkValue("lcdRw", 8'h00, {7'b0, lcdRw});
            if (msgCode != screenCode) begin
                changeSeen = 1'b1;
            end
            if (lcdEn && !prevEn) begin
                if (havePulse && lowCount < settleCycles) begin
                    $display("FAILED at %0t ns: lcdEn low clocks expected at least %0d got %0d",
                             $time, settleCycles, lowCount);
                    errorCount++;
                end
                if (changeSeen) begin
                    pos        = 0;  // new screen starts with function set
                    screenCode = msgCode;
                    changeSeen = 1'b0;
                end else if (pos == SCRIPT_LEN) begin
                    $display("ERROR at %0t ns: lcdEn pulse after a full screen, code unchanged",
                             $time);
                    errorCount++;
                    pos = 0;
                end
                highCount = 1;
                havePulse = 1'b1;
            end else if (lcdEn) begin
                highCount++;
            end else if (prevEn) begin
                if (highCount != ENABLE_CYCLES) begin
                    $display("FAILED at %0t ns: lcdEn high clocks expected %0d got %0d",
                             $time, ENABLE_CYCLES, highCount);
                    errorCount++;
                end
                wantEntry = expectedEntry(screenCode, pos);
                checkValue("lcdRs", {7'b0, wantEntry[ENTRY_WIDTH-1]}, {7'b0, lcdRs});
                checkValue("lcdData", wantEntry[7:0], lcdData);
                pos++;
                writesSeen++;
                if (pos == SCRIPT_LEN) begin
                    screensDone++;  // full screen, panel should go quiet
                end
                lowCount = 1;
            end else begin
                lowCount++;
            end
            prevEn = lcdEn;
        end
    end

endmodule

// File: bench/tbLcdMessage.sv
`timescale 1ns/1ns

module tbLcdMessage;
    import lcdPkg::*;

    localparam int SETTLE        = 20;
    localparam int NUM_TESTS     = 13;
    localparam int MID_WRITES    = 12;  // writes sent before a mid-screen change
    localparam int SCREEN_CYCLES = SCRIPT_LEN * (ENABLE_CYCLES + SETTLE + 8);
    localparam int CYCLE_LIMIT   = NUM_TESTS * 3 * SCREEN_CYCLES + 2000;

    logic                 iCLK;
    logic                 iRST_N;
    logic [MSG_WIDTH-1:0] msgCode;
    logic [7:0]           lcdData;
    logic                 lcdRw;
    logic                 lcdEn;
    logic                 lcdRs;
    int                   errorCount;
    int                   writesSeen;
    int                   screensDone;
    int                   cycleCount = 0;
    int                   passCount;
    int                   failCount;
    int                   testIdx;

    // code, full screens to wait, cut short by the next row's code
    logic [MSG_WIDTH-1:0] rowCode [NUM_TESTS] = '{
        8'd7, 8'd10, 8'd11, 8'd12, 8'd13, 8'd14, 8'd17,
        8'd25, 8'd33, 8'd3, 8'd30, 8'd38, 8'd0
    };
    int rowScreens [NUM_TESTS] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 1, 0, 1};
    logic rowMidChange [NUM_TESTS] = '{
        1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
        1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0
    };

    lcdMessageTop #(
        .settleCycles(SETTLE)
    ) dut (
        .iCLK   (iCLK),
        .iRST_N (iRST_N),
        .msgCode(msgCode),
        .lcdData(lcdData),
        .lcdRw  (lcdRw),
        .lcdEn  (lcdEn),
        .lcdRs  (lcdRs)
    );

    lcdBusMonitor #(
        .settleCycles(SETTLE)
    ) busMonitor (
        .iCLK       (iCLK),
        .iRST_N     (iRST_N),
        .msgCode    (msgCode),
        .lcdData    (lcdData),
        .lcdRw      (lcdRw),
        .lcdEn      (lcdEn),
        .lcdRs      (lcdRs),
        .errorCount (errorCount),
        .writesSeen (writesSeen),
        .screensDone(screensDone)
    );

    initial iCLK = 1'b0;
    always #4 iCLK = ~iCLK;

    // drive one row, then wait for its screens or its partial screen
    task automatic applyRow(input int idx);
        int errorsBefore;
        int target;
        errorsBefore = errorCount;
        @(posedge iCLK);
        msgCode <= rowCode[idx];
        if (rowMidChange[idx]) begin
            target = writesSeen + MID_WRITES;
            while (writesSeen < target) @(posedge iCLK);
        end else begin
            target = screensDone + rowScreens[idx];
            while (screensDone < target) @(posedge iCLK);
            repeat (2 * SCREEN_CYCLES) @(posedge iCLK);  // panel stays silent here
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %0d code %0d: ok", idx, rowCode[idx]);
        end else begin
            failCount++;
            $display("test %0d code %0d: %0d errors", idx, rowCode[idx],
                     errorCount - errorsBefore);
        end
    endtask

    initial begin
        iRST_N    = 1'b0;
        msgCode   = rowCode[0];  // first screen comes straight out of reset
        passCount = 0;
        failCount = 0;
        repeat (2) @(posedge iCLK);
        iRST_N <= 1'b1;
        for (testIdx = 0; testIdx < NUM_TESTS; testIdx++) begin
            applyRow(testIdx);
        end
        $display("tests passed %0d failed %0d, errors %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    always @(posedge iCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// File: verilog.f
verilog/lcdPkg.sv
verilog/lcdWriteIf.sv
verilog/screenRom.sv
verilog/displaySequencer.sv
verilog/lcdBusDriver.sv
verilog/lcdMessageTop.sv
bench/lcdBusMonitor.sv
bench/tbLcdMessage.sv
